//--- hdl/srio_regs_pkg.sv
/* SRIO SWRITE register map */

package srio_regs_pkg;

  ////////////////////////////////////////
  // Register space
  ////////////////////////////////////////

  // Implemented registers, index 7 is a hole that reads as zero
  localparam int num_regs = 7;

  // Word index, the three address bits above the byte offset
  typedef logic [2:0] reg_index_t;

  // Packer command word
  localparam reg_index_t idx_cmd = 3'd0;
  // Packer target address word
  localparam reg_index_t idx_addr = 3'd1;
  // Source and destination ID word
  localparam reg_index_t idx_srcdest = 3'd2;

  ////////////////////////////////////////
  // AXI responses
  ////////////////////////////////////////

  // BRESP / RRESP encoding
  typedef logic [1:0] resp_t;

  // Only OKAY is ever returned
  localparam resp_t resp_okay = 2'b00;

endpackage

//--- hdl/reg_write_if.sv
/* Register write strobe bus */

`timescale 1ns/1ns

interface reg_write_if
  import srio_regs_pkg::*;
#(
  parameter int data_width = 32
);

  // One-cycle write strobe, applied at the next rising edge
  logic                      en;
  // Target word index
  reg_index_t                index;
  // Write payload and byte enables
  logic [data_width-1:0]     data;
  logic [data_width/8-1:0]   strb;

  // Write channel side
  modport source (
    output en,
    output index,
    output data,
    output strb
  );

  // Register bank side
  modport sink (
    input  en,
    input  index,
    input  data,
    input  strb
  );

endinterface

//--- hdl/axi_lite_write_channel.sv
/* AXI4-Lite write channel */

`timescale 1ns/1ns

module axi_lite_write_channel
  import srio_regs_pkg::*;
#(
  parameter int data_width = 32,
  parameter int addr_width = 5
)
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Write address channel
  input  logic [addr_width-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  // Write data channel
  input  logic [data_width-1:0]   wdata,
  input  logic [data_width/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  // Write response channel
  output resp_t                   bresp,
  output logic                    bvalid,
  input  logic                    bready,
  // Strobe towards the register bank
  reg_write_if.source             wr
);

  // Byte offset bits below the word index
  localparam int addr_lsb = $clog2(data_width / 8);

  ////////////////////////////////////////
  // Handshake state
  ////////////////////////////////////////

  // Shared AWREADY/WREADY pulse
  logic       accept_q;
  // Response pending towards the master
  logic       bvalid_q;
  // Word index taken from AWADDR at accept time
  reg_index_t aw_index;
  // Start of a new accept cycle
  logic       accept_start;
  // Address and data handshake both complete this cycle
  logic       wr_fire;

  // Both valids present, no pulse in progress, no response outstanding
  assign accept_start = !accept_q && awvalid && wvalid && !bvalid_q;

  // AW and W complete together since one pulse drives both readies
  assign wr_fire = accept_q && awvalid && wvalid;

  ////////////////////////////////////////
  // Ready pulse
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      accept_q <= 1'b0;
    end
    else
    begin
      // High for exactly one cycle per write
      accept_q <= accept_start;
    end
  end

  // Address latch, only the index bits matter
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept_start)
    begin
      aw_index <= awaddr[addr_lsb +: $bits(reg_index_t)];
    end
  end

  ////////////////////////////////////////
  // Write response
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      bvalid_q <= 1'b0;
    end
    else if (wr_fire)
    begin
      // Response rises on the same edge the register updates
      bvalid_q <= 1'b1;
    end
    else if (bvalid_q && bready)
    begin
      bvalid_q <= 1'b0;
    end
  end

  assign awready = accept_q;
  assign wready  = accept_q;
  assign bvalid  = bvalid_q;
  // Every access is legal
  assign bresp   = resp_okay;

  ////////////////////////////////////////
  // Register bank strobe
  ////////////////////////////////////////

  // Latched index with live data and strobes, W still valid here
  assign wr.en    = wr_fire;
  assign wr.index = aw_index;
  assign wr.data  = wdata;
  assign wr.strb  = wstrb;

endmodule

//--- hdl/axi_lite_read_channel.sv
/* AXI4-Lite read channel */

`timescale 1ns/1ns

module axi_lite_read_channel
  import srio_regs_pkg::*;
#(
  parameter int data_width = 32,
  parameter int addr_width = 5
)
(
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // Read address channel
  input  logic [addr_width-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  // Read data channel
  output logic [data_width-1:0] rdata,
  output resp_t                 rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // Register bank lookup
  output reg_index_t            rd_index,
  input  logic [data_width-1:0] rd_data
);

  // Byte offset bits below the word index
  localparam int addr_lsb = $clog2(data_width / 8);

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  logic       arready_q;
  logic       rvalid_q;
  // Index latched at accept time
  reg_index_t ar_index;
  // New read address taken this cycle
  logic       accept_start;
  // AR handshake completes at the coming edge
  logic       rd_fire;

  // One read in flight, so wait for the previous data to drain
  assign accept_start = !arready_q && arvalid && !rvalid_q;
  assign rd_fire      = arready_q && arvalid;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready_q <= 1'b0;
    end
    else
    begin
      // Single-cycle pulse
      arready_q <= accept_start;
    end
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept_start)
    begin
      ar_index <= araddr[addr_lsb +: $bits(reg_index_t)];
    end
  end

  // Bank mux settles during the ARREADY cycle
  assign rd_index = ar_index;

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rvalid_q <= 1'b0;
      rdata    <= '0;
    end
    else if (rd_fire)
    begin
      // Capture the register and present it
      rvalid_q <= 1'b1;
      rdata    <= rd_data;
    end
    else if (rvalid_q && rready)
    begin
      // RDATA holds its value, only valid drops
      rvalid_q <= 1'b0;
    end
  end

  assign arready = arready_q;
  assign rvalid  = rvalid_q;
  assign rresp   = resp_okay;

endmodule

//--- hdl/swrite_reg_bank.sv
/* SWRITE control register bank */

`timescale 1ns/1ns

module swrite_reg_bank
  import srio_regs_pkg::*;
#(
  parameter int data_width = 32
)
(
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // Byte-masked write from the write channel
  reg_write_if.sink             wr,
  // Combinational read lookup
  input  reg_index_t            rd_index,
  output logic [data_width-1:0] rd_data,
  // Packer fields
  output logic [31:0]           cmd,
  output logic [31:0]           addr,
  output logic [31:0]           srcdest
);

  // Bytes per register
  localparam int num_bytes = data_width / 8;

  // Register storage, 0..2 feed the packer, 3..6 are scratch
  logic [data_width-1:0] regs [num_regs];
  // Write targets an implemented word
  logic                  wr_hit;

  // Index 7 is unmapped
  assign wr_hit = wr.en && (int'(wr.index) < num_regs);

  ////////////////////////////////////////
  // Strobe merge
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_hit)
    begin
      // Only the lanes with a set strobe change
      for (int b = 0; b < num_bytes; b++)
      begin
        if (wr.strb[b])
        begin
          regs[wr.index][b*8 +: 8] <= wr.data[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb
  begin
    // Unmapped index reads back zero
    rd_data = '0;
    if (int'(rd_index) < num_regs)
    begin
      rd_data = regs[rd_index];
    end
  end

  ////////////////////////////////////////
  // Packer outputs
  ////////////////////////////////////////

  // Fields are 32 bits wide at any bus width
  assign cmd     = regs[idx_cmd][31:0];
  assign addr    = regs[idx_addr][31:0];
  assign srcdest = regs[idx_srcdest][31:0];

endmodule

//--- hdl/srio_swrite_pack_if.sv
/* SRIO SWRITE packer AXI4-Lite slave */

`timescale 1ns/1ns

module srio_swrite_pack_if
  import srio_regs_pkg::*;
#(
  // 32 or 64, addr_width 5 or 6 to match
  parameter int data_width = 32,
  parameter int addr_width = 5
)
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // Write address
  input  logic [addr_width-1:0]   S_AXI_AWADDR,
  input  logic                    S_AXI_AWVALID,
  output logic                    S_AXI_AWREADY,
  // Write data
  input  logic [data_width-1:0]   S_AXI_WDATA,
  input  logic [data_width/8-1:0] S_AXI_WSTRB,
  input  logic                    S_AXI_WVALID,
  output logic                    S_AXI_WREADY,
  // Write response
  output resp_t                   S_AXI_BRESP,
  output logic                    S_AXI_BVALID,
  input  logic                    S_AXI_BREADY,
  // Read address
  input  logic [addr_width-1:0]   S_AXI_ARADDR,
  input  logic                    S_AXI_ARVALID,
  output logic                    S_AXI_ARREADY,
  // Read data
  output logic [data_width-1:0]   S_AXI_RDATA,
  output resp_t                   S_AXI_RRESP,
  output logic                    S_AXI_RVALID,
  input  logic                    S_AXI_RREADY,
  // Packer control fields
  output logic [31:0]             cmd,
  output logic [31:0]             addr,
  output logic [31:0]             srcdest
);

  // Write strobe path, write channel to bank
  reg_write_if #(.data_width(data_width)) wr_bus ();

  // Read lookup path
  reg_index_t            rd_index;
  logic [data_width-1:0] rd_data;

  ////////////////////////////////////////
  // Channels
  ////////////////////////////////////////

  axi_lite_write_channel #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) i_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .wr            (wr_bus.source)
  );

  axi_lite_read_channel #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) i_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

  ////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////

  swrite_reg_bank #(
    .data_width (data_width)
  ) i_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr            (wr_bus.sink),
    .rd_index      (rd_index),
    .rd_data       (rd_data),
    .cmd           (cmd),
    .addr          (addr),
    .srcdest       (srcdest)
  );

endmodule

//--- test/srio_swrite_pack_if_asserts.sv
/* AXI handshake assertions */

`timescale 1ns/1ns

module srio_swrite_pack_if_asserts #(
  parameter int data_width = 32
)
(
  input logic                  S_AXI_ACLK,
  input logic                  S_AXI_ARESETN,
  input logic                  S_AXI_AWREADY,
  input logic                  S_AXI_WREADY,
  input logic                  S_AXI_BVALID,
  input logic                  S_AXI_BREADY,
  input logic                  S_AXI_ARREADY,
  input logic                  S_AXI_RVALID,
  input logic                  S_AXI_RREADY,
  input logic [data_width-1:0] S_AXI_RDATA
);

  // One shared pulse drives both write readies
  a_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY == S_AXI_WREADY)
    else $error("AWREADY and WREADY differ");

  // Read address accept lasts a single cycle
  a_arready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_ARREADY |=> !S_AXI_ARREADY)
    else $error("ARREADY high for two cycles in a row");

  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else $error("BVALID dropped before BREADY");

  // Stalled read data stays put
  a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else $error("RDATA or RVALID changed while the master stalled");

endmodule

bind srio_swrite_pack_if srio_swrite_pack_if_asserts #(.data_width(data_width)) i_asserts (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .S_AXI_AWREADY (S_AXI_AWREADY),
  .S_AXI_WREADY  (S_AXI_WREADY),
  .S_AXI_BVALID  (S_AXI_BVALID),
  .S_AXI_BREADY  (S_AXI_BREADY),
  .S_AXI_ARREADY (S_AXI_ARREADY),
  .S_AXI_RVALID  (S_AXI_RVALID),
  .S_AXI_RREADY  (S_AXI_RREADY),
  .S_AXI_RDATA   (S_AXI_RDATA)
);

//--- test/tb_srio_swrite_pack_if.sv
/* SWRITE register slave testbench */

`timescale 1ns/1ns

module tb_srio_swrite_pack_if
  import srio_regs_pkg::*;
();

  // Cycles allowed for any single handshake
  localparam int timeout = 50;
  localparam logic [31:0] seed = 32'h15b58428;

  logic        S_AXI_ACLK;
  logic        S_AXI_ARESETN;
  logic [4:0]  S_AXI_AWADDR;
  logic        S_AXI_AWVALID;
  logic        S_AXI_AWREADY;
  logic [31:0] S_AXI_WDATA;
  logic [3:0]  S_AXI_WSTRB;
  logic        S_AXI_WVALID;
  logic        S_AXI_WREADY;
  resp_t       S_AXI_BRESP;
  logic        S_AXI_BVALID;
  logic        S_AXI_BREADY;
  logic [4:0]  S_AXI_ARADDR;
  logic        S_AXI_ARVALID;
  logic        S_AXI_ARREADY;
  logic [31:0] S_AXI_RDATA;
  resp_t       S_AXI_RRESP;
  logic        S_AXI_RVALID;
  logic        S_AXI_RREADY;
  logic [31:0] cmd;
  logic [31:0] addr;
  logic [31:0] srcdest;

  // Reference copy of the seven registers
  logic [31:0] model [num_regs];
  // Expected read data in issue order
  logic [31:0] exp_q [$];

  srio_swrite_pack_if i_dut (.*);

  always #5 S_AXI_ACLK = ~S_AXI_ACLK;

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Strobed lanes take the new byte while the rest keep the old one
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
      begin
        result[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Hole at index 7 reads zero
  function automatic logic [31:0] expected_read(input reg_index_t idx);
    logic [31:0] value;
    value = '0;
    if (int'(idx) < num_regs)
    begin
      value = model[idx];
    end
    return value;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      stop_on_error($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Compares every completed read and the packer fields after every write
  always @(posedge S_AXI_ACLK)
  begin
    if (S_AXI_ARESETN)
    begin
      if (S_AXI_BVALID && S_AXI_AWREADY)
      begin
        stop_on_error("AWREADY pulsed while a write response was still pending");
      end
      if (S_AXI_BVALID && S_AXI_BREADY)
      begin
        check_value("cmd", cmd, model[idx_cmd]);
        check_value("addr", addr, model[idx_addr]);
        check_value("srcdest", srcdest, model[idx_srcdest]);
      end
      if (S_AXI_RVALID && S_AXI_RREADY)
      begin
        if (exp_q.size() == 0)
        begin
          stop_on_error("Read data completed with no read outstanding");
        end
        else
        begin
          check_value("S_AXI_RDATA", S_AXI_RDATA, exp_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////
  // Bus transactions
  ////////////////////////////////////////

  // Drops the valids at AWREADY and counts edges until BVALID
  task automatic await_bresp(output int cnt);
    bit took;
    took = 1'b0;
    for (cnt = 1; cnt <= timeout; cnt++)
    begin
      @(posedge S_AXI_ACLK);
      if (S_AXI_AWREADY)
      begin
        took          = 1'b1;
        S_AXI_AWVALID <= 1'b0;
        S_AXI_WVALID  <= 1'b0;
        check_value("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'd1);
        // Readies answer one cycle after both valids are seen
        check_value("awready_latency", 32'(cnt), 32'd2);
      end
      if (S_AXI_BVALID)
      begin
        break;
      end
    end
    if (cnt > timeout)
    begin
      stop_on_error(took ? "Write response never arrived after the address handshake"
                         : "Write address handshake stalled, AWREADY never rose");
    end
  endtask

  // Overlap drives a write to the hole while the response is held back
  task automatic write_reg(input reg_index_t idx, input logic [31:0] data,
                           input logic [3:0] strb, input int hold, input bit overlap);
    int cnt;
    @(posedge S_AXI_ACLK);
    S_AXI_AWADDR  <= {idx, 2'b00};
    S_AXI_WDATA   <= data;
    S_AXI_WSTRB   <= strb;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID  <= 1'b1;
    await_bresp(cnt);
    // BVALID rises at edge 2 and is first sampled at edge 3
    check_value("bvalid_latency", 32'(cnt), 32'd3);
    check_value("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'(resp_okay));
    if (int'(idx) < num_regs)
    begin
      model[idx] = merge_bytes(model[idx], data, strb);
    end
    if (overlap)
    begin
      S_AXI_AWADDR  <= {3'd7, 2'b00};
      S_AXI_WDATA   <= $urandom;
      S_AXI_WSTRB   <= 4'hf;
      S_AXI_AWVALID <= 1'b1;
      S_AXI_WVALID  <= 1'b1;
    end
    repeat (hold)
    begin
      @(posedge S_AXI_ACLK);
      check_value("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'd1);
    end
    S_AXI_BREADY <= 1'b1;
    @(posedge S_AXI_ACLK);
    S_AXI_BREADY <= 1'b0;
    if (overlap)
    begin
      // Held-off write now drains, and changes nothing
      await_bresp(cnt);
      S_AXI_BREADY <= 1'b1;
      @(posedge S_AXI_ACLK);
      S_AXI_BREADY <= 1'b0;
    end
  endtask

  task automatic read_reg(input reg_index_t idx, input int hold);
    int          cnt;
    bit          took;
    logic [31:0] held;
    took = 1'b0;
    @(posedge S_AXI_ACLK);
    S_AXI_ARADDR  <= {idx, 2'b00};
    S_AXI_ARVALID <= 1'b1;
    for (cnt = 1; cnt <= timeout; cnt++)
    begin
      @(posedge S_AXI_ACLK);
      if (S_AXI_ARREADY)
      begin
        took          = 1'b1;
        S_AXI_ARVALID <= 1'b0;
        // ARREADY answers one cycle after ARVALID is seen
        check_value("arready_latency", 32'(cnt), 32'd2);
      end
      if (S_AXI_RVALID)
      begin
        break;
      end
    end
    if (cnt > timeout)
    begin
      stop_on_error(took ? "Read data never arrived after the address handshake"
                         : "Read address handshake stalled, ARREADY never rose");
    end
    check_value("rvalid_latency", 32'(cnt), 32'd3);
    check_value("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'(resp_okay));
    exp_q.push_back(expected_read(idx));
    held = S_AXI_RDATA;
    // RDATA must hold while the master stalls
    repeat (hold)
    begin
      @(posedge S_AXI_ACLK);
      check_value("S_AXI_RVALID", 32'(S_AXI_RVALID), 32'd1);
      check_value("S_AXI_RDATA", S_AXI_RDATA, held);
    end
    S_AXI_RREADY <= 1'b1;
    @(posedge S_AXI_ACLK);
    S_AXI_RREADY <= 1'b0;
  endtask

  // Reads all eight indexes including the hole in shuffled order
  task automatic read_all();
    reg_index_t order [8];
    reg_index_t tmp;
    int         j;
    for (int i = 0; i < 8; i++)
    begin
      order[i] = reg_index_t'(i);
    end
    for (int i = 7; i > 0; i--)
    begin
      j        = int'($urandom_range(i, 0));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 8; i++)
    begin
      read_reg(order[i], 0);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(seed));
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    for (int i = 0; i < num_regs; i++)
    begin
      model[i] = '0;
    end
    repeat (4) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    @(posedge S_AXI_ACLK);

    // Idle outputs and cleared registers after reset
    check_value("S_AXI_AWREADY", 32'(S_AXI_AWREADY), 32'd0);
    check_value("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'd0);
    check_value("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'd0);
    check_value("S_AXI_ARREADY", 32'(S_AXI_ARREADY), 32'd0);
    check_value("S_AXI_RVALID", 32'(S_AXI_RVALID), 32'd0);
    check_value("cmd", cmd, 32'd0);
    check_value("addr", addr, 32'd0);
    check_value("srcdest", srcdest, 32'd0);
    read_all();

    // Full words into every register
    for (int i = 0; i < num_regs; i++)
    begin
      write_reg(reg_index_t'(i), $urandom, 4'hf, 0, 1'b0);
    end
    read_all();

    // Random partial strobes
    repeat (24)
    begin
      write_reg(reg_index_t'($urandom_range(6, 0)), $urandom, 4'($urandom), 0, 1'b0);
    end
    read_all();

    // Unmapped index
    write_reg(3'd7, $urandom, 4'hf, 0, 1'b0);
    read_all();

    // Back-pressure on both response channels
    repeat (10)
    begin
      write_reg(reg_index_t'($urandom_range(6, 0)), $urandom, 4'($urandom),
                int'($urandom_range(8, 1)), 1'b1);
      read_reg(reg_index_t'($urandom_range(7, 0)), int'($urandom_range(8, 1)));
    end
    read_all();

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- project.f
hdl/srio_regs_pkg.sv
hdl/reg_write_if.sv
hdl/axi_lite_write_channel.sv
hdl/axi_lite_read_channel.sv
hdl/swrite_reg_bank.sv
hdl/srio_swrite_pack_if.sv
test/srio_swrite_pack_if_asserts.sv
test/tb_srio_swrite_pack_if.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_srio_swrite_pack_if
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
